// File: build.f
verilog/box_cfg_pkg.sv
verilog/box_mode_pkg.sv
verilog/prox_if.sv
verilog/mode_ctrl.sv
verilog/behavior_fsm.sv
verilog/proximity_eval.sv
verilog/actuator_drive.sv
verilog/led_status.sv
verilog/box_top.sv
verification/box_tb.sv

// File: Bender.yml
package:
  name: useless_box

sources:
  - files:
      - verilog/box_cfg_pkg.sv
      - verilog/box_mode_pkg.sv
      - verilog/prox_if.sv
      - verilog/mode_ctrl.sv
      - verilog/behavior_fsm.sv
      - verilog/proximity_eval.sv
      - verilog/actuator_drive.sv
      - verilog/led_status.sv
      - verilog/box_top.sv
  - target: test
    files:
      - verification/box_tb.sv

// File: verification/box_tb.sv
////////////////////////////////////////
// Testbench for the box controller
// Clock, reset, LCG stimulus, reference model
////////////////////////////////////////
`default_nettype none

module box_tb
    import box_cfg_pkg::*;
    import box_mode_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TD = TICK_DIV_DEF;
    localparam int DT = DODGE_TICKS_DEF;
    localparam int GD = GOOD_DIST_DEF;

    logic clk, rst, mode_btn, remote_mode, remote_switch, sw;
    logic fwd, back, left, right, ble_err;
    logic [UB_SEL_W-1:0] ub_sel;
    logic [3:0] ir;
    logic [DIST_W-1:0] dist_left, dist_right;
    logic servo_en, servo_sel, relay;
    logic [SERVO_W-1:0] servo_amt;
    logic [1:0] motor_cw, motor_ccw;
    logic [LED_W-1:0] led;

    // Reference model state
    mode_t m_mode;
    logic m_target, m_btn_q, m_known;
    int m_tcnt, m_dcnt;
    logic [LED_W-1:0] m_led;
    behav_t m_beh;
    arm_t m_arm;
    logic [31:0] seed;

    box_top #(.TICK_DIV(TD), .GOOD_DIST(GD), .DODGE_TICKS(DT)) DUT (.*);

    always #5 clk = !clk;

    function automatic logic [31:0] rand_word();
        seed = seed * 32'd1664525 + 32'd1013904223;
        // Fold high bits down, low LCG bits are weak
        return seed ^ (seed >> 15);
    endfunction

    function automatic logic [DIST_W-1:0] rand_dist();
        logic [31:0] w;
        w = rand_word();
        if (w[2:0] == 3'd0)
            return w[31:12];
        return DIST_W'(w[17:8] % 10'd40);
    endfunction

    // Near, away, side and lift from the current sensor inputs
    function automatic void eval_prox(output logic near, away, lc, hit,
                                      output logic [SERVO_W-1:0] lift);
        int rc;
        int mn;
        int sc;
        rc   = int'(dist_right) + SIDE_DELTA;
        near = (int'(dist_left) < GD) || (rc < GD);
        away = (int'(dist_left) > GD) && (rc > GD);
        lc   = int'(dist_left) > rc;
        hit  = (ir != 4'd0);
        mn   = lc ? rc : int'(dist_left);
        sc   = mn * LIFT_SCALE;
        if (hit || (!away && sc >= LIFT_LIMIT))
            lift = SERVO_FULL;
        else if (away)
            lift = '0;
        else
            lift = SERVO_W'(sc);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            abort_run($sformatf("ERR %0t %s got=%0h expected=%0h", $time, name, got, exp));
    endtask

    // Advance the model with the inputs the DUT sampled at this edge
    task automatic update_model();
        logic near, away, lc, hit, tick_now, done, adv;
        logic [SERVO_W-1:0] lift;
        logic [2:0] code;
        behav_t beh_n;
        arm_t arm_n;
        if (rst) begin
            m_mode   = MODE_NS;
            m_target = 1'b0;
            m_btn_q  = 1'b0;
            m_tcnt   = 0;
            m_led    = 16'h0001;
            m_beh    = BEH_RANDOM;
            m_arm    = ARM_IDLE;
            m_dcnt   = 0;
            m_known  = 1'b1;
        end else begin
            eval_prox(near, away, lc, hit, lift);
            tick_now = (m_tcnt == TD - 1);
            done     = (m_dcnt == DT);
            adv      = (mode_btn && !m_btn_q) || remote_mode;
            if (tick_now) begin
                case (m_mode)
                    MODE_NS: m_led = sw ? '1 : '0;
                    MODE_UB: begin
                        // One-hot of the behaviour unless a request is set
                        case (m_beh)
                            BEH_ADVANCE: code = 3'b100;
                            BEH_CLASSIC: code = 3'b001;
                            BEH_DODGE:   code = 3'b010;
                            default:     code = 3'b000;
                        endcase
                        if (ub_sel != 3'b000)
                            code = ub_sel;
                        m_led = {13'd0, code};
                    end
                    default: begin
                        if (left)
                            m_led = {m_led[0], m_led[LED_W-1:1]};
                        else if (right)
                            m_led = {m_led[LED_W-2:0], m_led[LED_W-1]};
                        else
                            m_led = 16'h0080;
                    end
                endcase
            end
            beh_n = BEH_RANDOM;
            if (m_mode == MODE_UB) begin
                case (ub_sel)
                    3'b001:  beh_n = BEH_CLASSIC;
                    3'b010:  beh_n = BEH_DODGE;
                    3'b100:  beh_n = BEH_ADVANCE;
                    // LFSR pick is not modelled
                    3'b000:  m_known = 1'b0;
                    default: beh_n = BEH_RANDOM;
                endcase
            end
            arm_n = ARM_IDLE;
            if ((m_beh == BEH_CLASSIC || m_beh == BEH_ADVANCE) && sw != m_target)
                arm_n = ARM_MOVE;
            if (m_beh == BEH_DODGE && ((m_arm == ARM_IDLE && near) || (m_arm == ARM_MOVE && !done)))
                arm_n = ARM_MOVE;
            if (!(m_beh == BEH_DODGE && m_arm == ARM_MOVE))
                m_dcnt = 0;
            else if (tick_now && !done)
                m_dcnt = m_dcnt + 1;
            if (remote_switch && m_mode != MODE_UB)
                m_target = !m_target;
            if (adv) begin
                case (m_mode)
                    MODE_NS: m_mode = MODE_UB;
                    MODE_UB: m_mode = MODE_UC;
                    default: m_mode = MODE_NS;
                endcase
            end
            m_btn_q = mode_btn;
            m_tcnt  = tick_now ? 0 : m_tcnt + 1;
            m_beh   = beh_n;
            m_arm   = arm_n;
        end
    endtask

    task automatic check_outputs();
        logic near, away, lc, hit, exp_en;
        logic [SERVO_W-1:0] lift, exp_amt;
        logic [1:0] exp_cw, exp_ccw;
        eval_prox(near, away, lc, hit, lift);
        exp_en  = 1'b0;
        exp_amt = '0;
        exp_cw  = 2'b00;
        exp_ccw = 2'b00;
        case (m_mode)
            MODE_NS: begin
                exp_en  = (sw != m_target);
                exp_amt = exp_en ? SERVO_FULL : '0;
            end
            MODE_UB: begin
                if (m_beh == BEH_CLASSIC && m_arm == ARM_MOVE && !hit) begin
                    exp_en  = 1'b1;
                    exp_amt = SERVO_FULL;
                end
                if (m_beh == BEH_ADVANCE) begin
                    exp_en  = 1'b1;
                    exp_amt = (m_arm == ARM_IDLE) ? lift : (hit ? '0 : SERVO_FULL);
                end
                // Dodging drives away from the closer side
                if (m_beh == BEH_DODGE && m_arm == ARM_MOVE && !away) begin
                    exp_ccw = lc ? 2'b11 : 2'b00;
                    exp_cw  = lc ? 2'b00 : 2'b11;
                end
            end
            default: begin
                if (!ble_err) begin
                    if (fwd)
                        exp_cw = 2'b11;
                    else if (back)
                        exp_ccw = 2'b11;
                    else if (left)
                        exp_cw = 2'b10;
                    else if (right)
                        exp_cw = 2'b01;
                end
            end
        endcase
        compare("relay", relay, (m_mode == MODE_NS) ? sw : 1'b0);
        compare("servo_sel", servo_sel, !sw);
        if (m_known) begin
            compare("servo_en", servo_en, exp_en);
            compare("servo_amt", servo_amt, exp_amt);
            compare("motor_cw", motor_cw, exp_cw);
            compare("motor_ccw", motor_ccw, exp_ccw);
            compare("led", led, m_led);
        end
    endtask

    task automatic clock_edge();
        @(posedge clk);
        update_model();
    endtask

    task automatic settle_and_check();
        @(negedge clk);
        check_outputs();
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            clock_edge();
            settle_and_check();
        end
    endtask

    // Button held for a few cycles, only the rising edge counts
    task automatic press_button();
        clock_edge();
        mode_btn <= 1'b1;
        settle_and_check();
        idle_cycles(3);
        clock_edge();
        mode_btn <= 1'b0;
        settle_and_check();
        idle_cycles(6);
    endtask

    task automatic pulse_remote_mode();
        clock_edge();
        remote_mode <= 1'b1;
        settle_and_check();
        clock_edge();
        remote_mode <= 1'b0;
        settle_and_check();
        idle_cycles(6);
    endtask

    // Near user starts the dodge, hover keeps it running until the count ends
    task automatic dodge_run(input int nl, nr, hl, hr);
        int n;
        clock_edge();
        dist_left  <= DIST_W'(nl);
        dist_right <= DIST_W'(nr);
        settle_and_check();
        n = 0;
        while ((motor_cw | motor_ccw) == 2'b00 && n < 10) begin
            clock_edge();
            settle_and_check();
            n++;
        end
        if ((motor_cw | motor_ccw) == 2'b00)
            abort_run("Dodge motors did not start for a near user");
        clock_edge();
        dist_left  <= DIST_W'(hl);
        dist_right <= DIST_W'(hr);
        settle_and_check();
        n = 0;
        while ((motor_cw | motor_ccw) != 2'b00 && n < DT * TD + 8) begin
            clock_edge();
            settle_and_check();
            n++;
        end
        if ((motor_cw | motor_ccw) != 2'b00)
            abort_run("Dodge motors still running after the dodge time");
        clock_edge();
        dist_left  <= DIST_W'(100);
        dist_right <= DIST_W'(100);
        settle_and_check();
        idle_cycles(4);
    endtask

    initial begin
        logic [31:0] r;
        int n;
        clk = 1'b0;
        rst = 1'b1;
        seed = 32'hcd5e;
        {mode_btn, remote_mode, remote_switch, sw} = 4'b0000;
        {fwd, back, left, right, ble_err} = 5'b00000;
        ub_sel = 3'b000;
        ir = 4'd0;
        dist_left = DIST_W'(100);
        dist_right = DIST_W'(100);
        repeat (8) clock_edge();
        rst <= 1'b0;
        settle_and_check();
        compare("led", led, 16'h0001);
        compare("servo_en", servo_en, 1'b0);
        compare("motors", {motor_cw, motor_ccw}, 4'b0000);

        // Mode cycling NS -> UB -> UC -> NS
        clock_edge();
        sw <= 1'b1;
        ub_sel <= 3'b011;
        settle_and_check();
        idle_cycles(6);
        press_button();
        pulse_remote_mode();
        press_button();

        // NS, relay and servo against the target
        for (n = 0; n < 80; n++) begin
            clock_edge();
            r = rand_word();
            sw <= r[0];
            remote_switch <= (r[3:1] == 3'd0);
            settle_and_check();
        end

        // UC, motor priority and LED rotation
        clock_edge();
        remote_switch <= 1'b0;
        settle_and_check();
        pulse_remote_mode();
        pulse_remote_mode();
        for (n = 0; n < 120; n++) begin
            clock_edge();
            r = rand_word();
            {fwd, back, left, right} <= r[3:0] & r[7:4];
            ble_err <= (r[10:8] == 3'd0);
            settle_and_check();
        end

        // UB advance then classic with random sensors
        clock_edge();
        {fwd, back, left, right, ble_err} <= 5'b00000;
        settle_and_check();
        pulse_remote_mode();
        pulse_remote_mode();
        for (n = 0; n < 160; n++) begin
            clock_edge();
            r = rand_word();
            ub_sel <= (n < 80) ? UB_REQ_ADVANCE : UB_REQ_CLASSIC;
            if (r[1:0] == 2'd0)
                sw <= r[2];
            ir <= (r[5:3] == 3'd0) ? r[9:6] : 4'd0;
            dist_left <= rand_dist();
            dist_right <= rand_dist();
            settle_and_check();
        end

        // UB dodge, user close on the left then on the right
        clock_edge();
        ub_sel <= UB_REQ_DODGE;
        sw <= m_target;
        ir <= 4'd0;
        dist_left <= DIST_W'(100);
        dist_right <= DIST_W'(100);
        settle_and_check();
        idle_cycles(3);
        dodge_run(10, 30, 20, 17);
        dodge_run(30, 5, 21, 16);

        // UB random request settles on a legal behaviour
        clock_edge();
        ub_sel <= 3'b011;
        settle_and_check();
        idle_cycles(3);
        clock_edge();
        ub_sel <= UB_REQ_RANDOM;
        settle_and_check();
        n = 0;
        while (!(led[2:0] inside {3'b001, 3'b010, 3'b100}) && n < 200) begin
            clock_edge();
            settle_and_check();
            n++;
        end
        if (!(led[2:0] inside {3'b001, 3'b010, 3'b100}))
            abort_run("Random request never showed a legal behaviour on the LEDs");
        compare("led_upper", led[LED_W-1:3], 13'd0);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/box_top.sv
////////////////////////////////////////
// Useless box controller top level
////////////////////////////////////////
`default_nettype none

module box_top
    import box_cfg_pkg::*;
    import box_mode_pkg::*;
#(
    parameter int TICK_DIV    = TICK_DIV_DEF,
    parameter int GOOD_DIST   = GOOD_DIST_DEF,
    parameter int DODGE_TICKS = DODGE_TICKS_DEF
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                mode_btn,
    input  logic                remote_mode,
    input  logic                remote_switch,
    input  logic [UB_SEL_W-1:0] ub_sel,
    input  logic                sw,
    input  logic [3:0]          ir,
    input  logic [DIST_W-1:0]   dist_left,
    input  logic [DIST_W-1:0]   dist_right,
    input  logic                fwd,
    input  logic                back,
    input  logic                left,
    input  logic                right,
    input  logic                ble_err,
    output logic                servo_en,
    output logic                servo_sel,
    output logic [SERVO_W-1:0]  servo_amt,
    output logic [1:0]          motor_cw,
    output logic [1:0]          motor_ccw,
    output logic                relay,
    output logic [LED_W-1:0]    led
);

    mode_t  mode;
    logic   sw_target;
    logic   tick;
    behav_t behav;
    arm_t   arm;
    logic   dodging;

    prox_if prox ();

    mode_ctrl #(.TICK_DIV(TICK_DIV)) u_mode_ctrl (
        .clk(clk), .rst(rst), .mode_btn(mode_btn), .remote_mode(remote_mode),
        .remote_switch(remote_switch), .mode(mode), .sw_target(sw_target), .tick(tick)
    );

    proximity_eval #(.GOOD_DIST(GOOD_DIST)) u_proximity_eval (
        .dist_left(dist_left), .dist_right(dist_right), .ir(ir), .prox(prox.src)
    );

    behavior_fsm #(.DODGE_TICKS(DODGE_TICKS)) u_behavior_fsm (
        .clk(clk), .rst(rst), .mode(mode), .ub_sel(ub_sel), .sw(sw),
        .sw_target(sw_target), .tick(tick), .prox(prox.dst), .behav(behav),
        .arm(arm), .dodging(dodging)
    );

    actuator_drive u_actuator_drive (
        .mode(mode), .behav(behav), .arm(arm), .dodging(dodging), .sw(sw),
        .sw_target(sw_target), .fwd(fwd), .back(back), .left(left), .right(right),
        .ble_err(ble_err), .prox(prox.dst), .servo_en(servo_en), .servo_sel(servo_sel),
        .servo_amt(servo_amt), .motor_cw(motor_cw), .motor_ccw(motor_ccw), .relay(relay)
    );

    led_status u_led_status (
        .clk(clk), .rst(rst), .tick(tick), .mode(mode), .sw(sw), .ub_sel(ub_sel),
        .behav(behav), .left(left), .right(right), .led(led)
    );

endmodule

`default_nettype wire

// File: verilog/led_status.sv
////////////////////////////////////////
// Status LED pattern per mode
////////////////////////////////////////
`default_nettype none

module led_status
    import box_cfg_pkg::*;
    import box_mode_pkg::*;
(
    input  logic                clk,
    input  logic                rst,
    input  logic                tick,
    input  mode_t               mode,
    input  logic                sw,
    input  logic [UB_SEL_W-1:0] ub_sel,
    input  behav_t              behav,
    input  logic                left,
    input  logic                right,
    output logic [LED_W-1:0]    led
);

    // Idle car pattern sits mid bar
    localparam logic [LED_W-1:0] LED_MID = LED_W'(1) << (LED_W / 2 - 1);

    logic [LED_W-1:0] led_next;
    logic [2:0]       ub_code;

    // Request code, or the active behaviour one-hot
    always_comb begin
        case (behav)
            BEH_ADVANCE: ub_code = UB_REQ_ADVANCE;
            BEH_CLASSIC: ub_code = UB_REQ_CLASSIC;
            BEH_DODGE:   ub_code = UB_REQ_DODGE;
            default:     ub_code = 3'b000;
        endcase
        if (ub_sel != UB_REQ_RANDOM) begin
            ub_code = ub_sel;
        end
    end

    always_comb begin
        case (mode)
            MODE_NS: led_next = sw ? '1 : '0;
            MODE_UB: led_next = {{(LED_W - 3){1'b0}}, ub_code};
            MODE_UC: begin
                if (left) begin
                    led_next = {led[0], led[LED_W-1:1]};
                end else if (right) begin
                    led_next = {led[LED_W-2:0], led[LED_W-1]};
                end else begin
                    led_next = LED_MID;
                end
            end
            default: led_next = led;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            led <= LED_W'(1);
        end else if (tick) begin
            led <= led_next;
        end
    end

endmodule

`default_nettype wire

// File: verilog/actuator_drive.sv
////////////////////////////////////////
// Servo, motor and relay commands
////////////////////////////////////////
`default_nettype none

module actuator_drive
    import box_cfg_pkg::*;
    import box_mode_pkg::*;
(
    input  mode_t              mode,
    input  behav_t             behav,
    input  arm_t               arm,
    input  logic               dodging,
    input  logic               sw,
    input  logic               sw_target,
    input  logic               fwd,
    input  logic               back,
    input  logic               left,
    input  logic               right,
    input  logic               ble_err,
    prox_if.dst                prox,
    output logic               servo_en,
    output logic               servo_sel,
    output logic [SERVO_W-1:0] servo_amt,
    output logic [1:0]         motor_cw,
    output logic [1:0]         motor_ccw,
    output logic               relay
);

    // Motor bit positions
    localparam int MOT_L = 0;
    localparam int MOT_R = 1;

    // Servo on the far side of the lever
    assign servo_sel = !sw;
    assign relay     = (mode == MODE_NS) ? sw : 1'b0;

    always_comb begin
        servo_en  = 1'b0;
        servo_amt = '0;
        case (mode)
            MODE_NS: begin
                if (sw != sw_target) begin
                    servo_en  = 1'b1;
                    servo_amt = SERVO_FULL;
                end
            end
            MODE_UB: begin
                if ((behav == BEH_CLASSIC) && (arm == ARM_MOVE) && !prox.ir_hit) begin
                    servo_en  = 1'b1;
                    servo_amt = SERVO_FULL;
                end else if (behav == BEH_ADVANCE) begin
                    servo_en = 1'b1;
                    // Hover at the lift, then flip unless a hand blocks
                    if (arm == ARM_IDLE) begin
                        servo_amt = prox.lift;
                    end else if (!prox.ir_hit) begin
                        servo_amt = SERVO_FULL;
                    end
                end
            end
            default: servo_en = 1'b0;
        endcase
    end

    always_comb begin
        motor_cw  = 2'b00;
        motor_ccw = 2'b00;
        if (mode == MODE_UB) begin
            // Drive away from the closer side
            if (dodging && !prox.user_away) begin
                if (prox.left_closer) begin
                    motor_ccw = 2'b11;
                end else begin
                    motor_cw = 2'b11;
                end
            end
        end else if ((mode == MODE_UC) && !ble_err) begin
            if (fwd) begin
                motor_cw = 2'b11;
            end else if (back) begin
                motor_ccw = 2'b11;
            end else if (left) begin
                motor_cw[MOT_R] = 1'b1;
            end else if (right) begin
                motor_cw[MOT_L] = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/proximity_eval.sv
////////////////////////////////////////
// Proximity verdict from sonar and IR
// Near, away, closer side and arm lift
////////////////////////////////////////
`default_nettype none

module proximity_eval
    import box_cfg_pkg::*;
#(
    parameter int GOOD_DIST = GOOD_DIST_DEF
) (
    input  logic [DIST_W-1:0] dist_left,
    input  logic [DIST_W-1:0] dist_right,
    input  logic [3:0]        ir,
    prox_if.src               prox
);

    // One spare bit for the side offset, two more for the scale
    logic [DIST_W:0]   right_c;
    logic [DIST_W:0]   min_dist;
    logic [DIST_W+2:0] scaled;

    assign right_c  = dist_right + (DIST_W + 1)'(SIDE_DELTA);
    assign min_dist = prox.left_closer ? right_c : {1'b0, dist_left};
    assign scaled   = min_dist * (DIST_W + 3)'(LIFT_SCALE);

    assign prox.user_near   = (dist_left < GOOD_DIST) || (right_c < GOOD_DIST);
    assign prox.user_away   = (dist_left > GOOD_DIST) && (right_c > GOOD_DIST);
    assign prox.left_closer = (dist_left > right_c);
    assign prox.ir_hit      = |ir;

    // Arm rises as the user comes closer
    always_comb begin
        if (prox.ir_hit) begin
            prox.lift = SERVO_FULL;
        end else if (prox.user_away) begin
            prox.lift = '0;
        end else if (scaled >= LIFT_LIMIT) begin
            prox.lift = SERVO_FULL;
        end else begin
            prox.lift = scaled[SERVO_W-1:0];
        end
    end

endmodule

`default_nettype wire

// File: verilog/behavior_fsm.sv
////////////////////////////////////////
// UB behaviour and arm FSMs
// Dodge counter and random source
////////////////////////////////////////
`default_nettype none

module behavior_fsm
    import box_cfg_pkg::*;
    import box_mode_pkg::*;
#(
    parameter int DODGE_TICKS = DODGE_TICKS_DEF
) (
    input  logic                clk,
    input  logic                rst,
    input  mode_t               mode,
    input  logic [UB_SEL_W-1:0] ub_sel,
    input  logic                sw,
    input  logic                sw_target,
    input  logic                tick,
    prox_if.dst                 prox,
    output behav_t              behav,
    output arm_t                arm,
    output logic                dodging
);

    localparam int CNT_W = $clog2(DODGE_TICKS + 1);
    localparam logic [CNT_W-1:0] CNT_END = CNT_W'(DODGE_TICKS);

    logic [7:0]       lfsr;
    logic [CNT_W-1:0] dodge_cnt;
    logic             dodge_done;
    logic             sw_ok;
    behav_t           behav_next;
    arm_t             arm_next;

    assign dodge_done = (dodge_cnt == CNT_END);
    // Switch already sits where it should
    assign sw_ok      = (sw == sw_target);
    assign dodging    = (behav == BEH_DODGE) && (arm == ARM_MOVE);

    always_comb begin
        behav_next = BEH_RANDOM;
        if (mode == MODE_UB) begin
            case (ub_sel)
                UB_REQ_RANDOM: begin
                    case (behav)
                        BEH_RANDOM: begin
                            // Roll a new behaviour from the LFSR
                            case (lfsr[1:0])
                                2'd0:    behav_next = BEH_ADVANCE;
                                2'd1:    behav_next = BEH_CLASSIC;
                                2'd2:    behav_next = BEH_DODGE;
                                default: behav_next = BEH_RANDOM;
                            endcase
                        end
                        BEH_DODGE: begin
                            if (!dodge_done) begin
                                behav_next = BEH_DODGE;
                            end
                        end
                        default: begin
                            // Classic or advance, done once the switch is back
                            if (!((arm == ARM_MOVE) && sw_ok)) begin
                                behav_next = behav;
                            end
                        end
                    endcase
                end
                UB_REQ_CLASSIC: behav_next = BEH_CLASSIC;
                UB_REQ_DODGE:   behav_next = BEH_DODGE;
                UB_REQ_ADVANCE: behav_next = BEH_ADVANCE;
                default:        behav_next = BEH_RANDOM;
            endcase
        end
    end

    always_comb begin
        arm_next = ARM_IDLE;
        case (behav)
            BEH_CLASSIC, BEH_ADVANCE: begin
                if (!sw_ok) begin
                    arm_next = ARM_MOVE;
                end
            end
            BEH_DODGE: begin
                // Start on a near user, hold until the count ends
                if (arm == ARM_IDLE) begin
                    if (prox.user_near) begin
                        arm_next = ARM_MOVE;
                    end
                end else if (!dodge_done) begin
                    arm_next = ARM_MOVE;
                end
            end
            default: arm_next = ARM_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            behav     <= BEH_RANDOM;
            arm       <= ARM_IDLE;
            lfsr      <= 8'h01;
            dodge_cnt <= '0;
        end else begin
            behav <= behav_next;
            arm   <= arm_next;
            // Fibonacci taps 8 6 5 4
            lfsr  <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
            if (!dodging) begin
                dodge_cnt <= '0;
            end else if (tick && !dodge_done) begin
                dodge_cnt <= dodge_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/mode_ctrl.sv
////////////////////////////////////////
// Mode FSM and target switch register
// Tick enable generator
////////////////////////////////////////
`default_nettype none

module mode_ctrl
    import box_cfg_pkg::*;
    import box_mode_pkg::*;
#(
    parameter int TICK_DIV = TICK_DIV_DEF
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  mode_btn,
    input  logic  remote_mode,
    input  logic  remote_switch,
    output mode_t mode,
    output logic  sw_target,
    output logic  tick
);

    localparam int TCNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [TCNT_W-1:0] TCNT_END = TCNT_W'(TICK_DIV - 1);

    logic              btn_q;
    logic              advance;
    logic [TCNT_W-1:0] tick_cnt;

    // Rising edge of the button or a remote request
    assign advance = (mode_btn && !btn_q) || remote_mode;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            btn_q     <= 1'b0;
            mode      <= MODE_NS;
            sw_target <= 1'b0;
        end else begin
            btn_q <= mode_btn;
            if (advance) begin
                case (mode)
                    MODE_NS: mode <= MODE_UB;
                    MODE_UB: mode <= MODE_UC;
                    default: mode <= MODE_NS;
                endcase
            end
            // Remote toggle ignored while the box plays
            if (remote_switch && (mode != MODE_UB)) begin
                sw_target <= !sw_target;
            end
        end
    end

    // Free running divider, tick on the last count
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tick_cnt <= '0;
        end else if (tick_cnt == TCNT_END) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    assign tick = (tick_cnt == TCNT_END);

endmodule

`default_nettype wire

// File: verilog/prox_if.sv
////////////////////////////////////////
// Proximity verdict bundle
// src from the evaluator, dst for its users
////////////////////////////////////////
`default_nettype none

interface prox_if
    import box_cfg_pkg::*;
();

    // Either side closer than the good distance
    logic               user_near;
    // Both sides beyond the good distance
    logic               user_away;
    // User nearer the right-hand sensor
    logic               left_closer;
    logic [SERVO_W-1:0] lift;
    logic               ir_hit;

    modport src (
        output user_near, user_away, left_closer, lift, ir_hit
    );

    modport dst (
        input user_near, user_away, left_closer, lift, ir_hit
    );

endinterface

`default_nettype wire

// File: verilog/box_mode_pkg.sv
////////////////////////////////////////
// Mode, behaviour and arm encodings
// UB request codes from the selector
////////////////////////////////////////
`default_nettype none

package box_mode_pkg;

    // Operating mode, cycled NS -> UB -> UC
    typedef enum logic [1:0] {
        MODE_NS = 2'b00,
        MODE_UB = 2'b01,
        MODE_UC = 2'b10
    } mode_t;

    // Active useless box behaviour
    typedef enum logic [1:0] {
        BEH_RANDOM  = 2'b00,
        BEH_CLASSIC = 2'b01,
        BEH_DODGE   = 2'b10,
        BEH_ADVANCE = 2'b11
    } behav_t;

    typedef enum logic {
        ARM_IDLE = 1'b0,
        ARM_MOVE = 1'b1
    } arm_t;

    // Request codes, anything else is invalid
    localparam logic [2:0] UB_REQ_RANDOM  = 3'b000;
    localparam logic [2:0] UB_REQ_CLASSIC = 3'b001;
    localparam logic [2:0] UB_REQ_DODGE   = 3'b010;
    localparam logic [2:0] UB_REQ_ADVANCE = 3'b100;

endpackage

`default_nettype wire

// File: verilog/box_cfg_pkg.sv
////////////////////////////////////////
// Numeric configuration of the box
// Widths, distance rules, dodge and tick timing
////////////////////////////////////////
`default_nettype none

package box_cfg_pkg;

    // Datapath widths
    localparam int DIST_W   = 20;
    localparam int SERVO_W  = 5;
    localparam int LED_W    = 16;
    localparam int UB_SEL_W = 3;

    // Servo amount for a full swing of the arm
    localparam logic [SERVO_W-1:0] SERVO_FULL = '1;

    // Proximity rules, distances in cm
    localparam int GOOD_DIST_DEF = 20;
    // Right sensor sits closer to the switch
    localparam int SIDE_DELTA    = 4;
    localparam int LIFT_SCALE    = 3;
    localparam int LIFT_LIMIT    = 25;

    // Timing in ticks and in clocks per tick
    localparam int DODGE_TICKS_DEF = 75;
    localparam int TICK_DIV_DEF    = 4;

endpackage

`default_nettype wire
